/* board_cfg_pkg.sv */
// board clock, rtc divider, reset hold and fan pwm constants
package board_cfg_pkg;

  //////////////////////////////
  // clocking
  //////////////////////////////

  // soc_clk as delivered by the board clock tree
  localparam int unsigned soc_clk_hz = 32'd50_000_000;

  // rtc runs at 1 MHz
  // half period in soc_clk cycles is soc_clk_hz / (2 * 1 MHz)
  localparam int unsigned rtc_half_period = soc_clk_hz / 32'd2_000_000;

  // wide enough for 0 .. rtc_half_period-1
  localparam int unsigned rtc_cnt_w = 5;

  //////////////////////////////
  // reset sequencing
  //////////////////////////////

  // rtc ticks the soc stays in reset after button release
  localparam int unsigned rst_hold_ticks = 32'd4;

  // counts held ticks up to rst_hold_ticks-1
  localparam int unsigned hold_cnt_w = 3;

  //////////////////////////////
  // fan control
  //////////////////////////////

  // 16 pwm steps per period, one per soc_clk cycle
  localparam int unsigned fan_cnt_w = 4;

endpackage

/* board_glue_top.sv */
// board glue top with rtc timer, reset sequencer, sd, i2c and fan blocks
`timescale 1ns/1ps

module board_glue_top
  import board_io_pkg::*;
(
  input  logic       soc_clk,
  input  logic       rst_n,
  // board reset button, active high
  input  logic       sys_rst_i,
  input  spi_host_t  spi_host_i,
  input  logic       sd_dat0_i,
  input  i2c_host_t  i2c_host_i,
  input  logic       i2c_scl_i,
  input  logic       i2c_sda_i,
  input  logic [3:0] fan_sw_i,
  output logic       soc_rst_n_o,
  output logic       rtc_clk_o,
  output sd_pads_t   sd_pads_o,
  output logic       spi_miso_o,
  output i2c_pads_t  i2c_pads_o,
  output logic       i2c_scl_sync_o,
  output logic       i2c_sda_sync_o,
  output logic       fan_pwm_o
);

  // half-period pulse from the rtc divider
  logic tick;
  // pads follow the soc out of reset
  logic pads_live;

  //////////////////////////////
  // time base and reset
  //////////////////////////////

  board_timer i_board_timer (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n     ),
    .tick_o    ( tick      ),
    .rtc_clk_o ( rtc_clk_o )
  );

  rst_seq i_rst_seq (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .sys_rst_i   ( sys_rst_i   ),
    .tick_i      ( tick        ),
    .soc_rst_n_o ( soc_rst_n_o ),
    .pads_live_o ( pads_live   )
  );

  //////////////////////////////
  // pads
  //////////////////////////////

  sd_spi_pads i_sd_spi_pads (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .pads_live_i ( pads_live   ),
    .spi_host_i  ( spi_host_i  ),
    .sd_dat0_i   ( sd_dat0_i   ),
    .sd_pads_o   ( sd_pads_o   ),
    .spi_miso_o  ( spi_miso_o  )
  );

  i2c_pads i_i2c_pads (
    .soc_clk        ( soc_clk        ),
    .rst_n          ( rst_n          ),
    .pads_live_i    ( pads_live      ),
    .i2c_host_i     ( i2c_host_i     ),
    .i2c_scl_i      ( i2c_scl_i      ),
    .i2c_sda_i      ( i2c_sda_i      ),
    .i2c_pads_o     ( i2c_pads_o     ),
    .i2c_scl_sync_o ( i2c_scl_sync_o ),
    .i2c_sda_sync_o ( i2c_sda_sync_o )
  );

  // fan runs from board reset, independent of the soc
  fan_pwm i_fan_pwm (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n     ),
    .fan_sw_i  ( fan_sw_i  ),
    .fan_pwm_o ( fan_pwm_o )
  );

endmodule

/* board_io_pkg.sv */
// pad and host side structs, sd idle value and reset sequencer state enum
package board_io_pkg;

  //////////////////////////////
  // spi host and sd slot
  //////////////////////////////

  // spi host pins as driven by the soc
  typedef struct packed {
    logic       sck;
    logic       sck_en;
    logic [1:0] csb;
    logic [1:0] csb_en;
    logic [3:0] sd_out;
    logic [3:0] sd_en;
  } spi_host_t;

  // sd slot in spi mode
  // dat3 carries chip select, cmd carries mosi
  typedef struct packed {
    logic       sclk;
    logic       cmd;
    logic       dat3;
    logic [1:0] dat2_1;
    logic       reset;
  } sd_pads_t;

  // lines idle high, card powered
  localparam sd_pads_t sd_pads_idle = '{
    sclk:   1'b1,
    cmd:    1'b1,
    dat3:   1'b1,
    dat2_1: 2'b11,
    reset:  1'b0
  };

  //////////////////////////////
  // i2c
  //////////////////////////////

  // push-pull view from the soc i2c host
  typedef struct packed {
    logic scl_out;
    logic scl_en;
    logic sda_out;
    logic sda_en;
  } i2c_host_t;

  // open-drain pull-low enables
  // pad floats high through the board pull-up when oe is clear
  typedef struct packed {
    logic scl_oe;
    logic sda_oe;
  } i2c_pads_t;

  //////////////////////////////
  // reset sequencer
  //////////////////////////////

  typedef enum logic [1:0] {
    rst_assert = 2'd0,
    rst_hold   = 2'd1,
    rst_run    = 2'd2
  } rst_state_e;

endpackage

/* board_timer.sv */
// rtc half-period counter producing the 1 MHz rtc clock and a tick pulse
`timescale 1ns/1ps

module board_timer
  import board_cfg_pkg::*;
(
  input  logic soc_clk,
  input  logic rst_n,
  output logic tick_o,
  output logic rtc_clk_o
);

  // position within the current rtc half period
  logic [rtc_cnt_w-1:0] cnt_q;
  logic                 wrap;

  // last cycle of a half period
  assign wrap = (cnt_q == rtc_cnt_w'(rtc_half_period - 1));

  // tick marks every half period
  // also the time base of the reset sequencer
  assign tick_o = wrap;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q     <= '0;
      rtc_clk_o <= 1'b0;
    end else begin
      if (wrap) begin
        cnt_q     <= '0;
        // toggle lands on the edge that closes the half period
        rtc_clk_o <= ~rtc_clk_o;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // one tick per half period, never back to back
  a_tick_single : assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    tick_o |=> !tick_o
  );

endmodule

/* fan_pwm.sv */
// fan switch register and 16-step pwm generator
`timescale 1ns/1ps

module fan_pwm
  import board_cfg_pkg::*;
(
  input  logic       soc_clk,
  input  logic       rst_n,
  input  logic [3:0] fan_sw_i,
  output logic       fan_pwm_o
);

  // duty setting in steps of 1/16
  logic [fan_cnt_w-1:0] duty_q;
  // free-running step position
  logic [fan_cnt_w-1:0] step_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      duty_q    <= '0;
      step_q    <= '0;
      fan_pwm_o <= 1'b0;
    end else begin
      // switches are slow, one flop is enough
      duty_q    <= fan_sw_i;
      // wraps naturally every 16 cycles
      step_q    <= step_q + 1'b1;
      // high for duty_q steps of each period
      fan_pwm_o <= (step_q < duty_q);
    end
  end

endmodule

/* files.f */
board_cfg_pkg.sv
board_io_pkg.sv
board_timer.sv
rst_seq.sv
sd_spi_pads.sv
i2c_pads.sv
fan_pwm.sv
board_glue_top.sv
tb_board_glue.sv

/* i2c_pads.sv */
// open-drain scl/sda pull-low enables and two-flop bus line synchronizers
`timescale 1ns/1ps

module i2c_pads
  import board_io_pkg::*;
(
  input  logic      soc_clk,
  input  logic      rst_n,
  input  logic      pads_live_i,
  input  i2c_host_t i2c_host_i,
  input  logic      i2c_scl_i,
  input  logic      i2c_sda_i,
  output i2c_pads_t i2c_pads_o,
  output logic      i2c_scl_sync_o,
  output logic      i2c_sda_sync_o
);

  // {scl, sda} per stage
  logic [1:0] line_meta_q;
  logic [1:0] line_sync_q;

  //////////////////////////////
  // drive side
  //////////////////////////////

  // pull low only for an enabled zero
  // a driven one is left to the pull-up
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      i2c_pads_o <= '0;
    end else begin
      i2c_pads_o.scl_oe <= pads_live_i & i2c_host_i.scl_en & ~i2c_host_i.scl_out;
      i2c_pads_o.sda_oe <= pads_live_i & i2c_host_i.sda_en & ~i2c_host_i.sda_out;
    end
  end

  //////////////////////////////
  // sense side
  //////////////////////////////

  // idle bus reads high
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      line_meta_q <= 2'b11;
      line_sync_q <= 2'b11;
    end else begin
      line_meta_q <= {i2c_scl_i, i2c_sda_i};
      line_sync_q <= line_meta_q;
    end
  end

  assign i2c_scl_sync_o = line_sync_q[1];
  assign i2c_sda_sync_o = line_sync_q[0];

endmodule

/* rst_seq.sv */
// reset release fsm holding soc reset and pad release after the board button
`timescale 1ns/1ps

module rst_seq
  import board_cfg_pkg::*;
  import board_io_pkg::*;
(
  input  logic soc_clk,
  input  logic rst_n,
  input  logic sys_rst_i,
  input  logic tick_i,
  output logic soc_rst_n_o,
  output logic pads_live_o
);

  // button sync, bit 1 is the stable copy
  logic [1:0]            btn_sync_q;
  logic                  btn_sync;
  rst_state_e            state_q;
  rst_state_e            state_d;
  logic [hold_cnt_w-1:0] hold_cnt_q;
  logic [hold_cnt_w-1:0] hold_cnt_d;
  logic                  last_tick;

  assign btn_sync  = btn_sync_q[1];
  assign last_tick = tick_i && (hold_cnt_q == hold_cnt_w'(rst_hold_ticks - 1));

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    state_d    = state_q;
    hold_cnt_d = hold_cnt_q;
    case (state_q)
      rst_assert: begin
        hold_cnt_d = '0;
        // button released, start counting ticks
        if (!btn_sync) begin
          state_d = rst_hold;
        end
      end
      rst_hold: begin
        if (last_tick) begin
          state_d = rst_run;
        end else if (tick_i) begin
          hold_cnt_d = hold_cnt_q + 1'b1;
        end
      end
      rst_run: begin
        hold_cnt_d = '0;
      end
      default: begin
        state_d = rst_assert;
      end
    endcase
    // a press wins from any state
    if (btn_sync) begin
      state_d    = rst_assert;
      hold_cnt_d = '0;
    end
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      // treat the button as pressed until sampled
      btn_sync_q  <= 2'b11;
      state_q     <= rst_assert;
      hold_cnt_q  <= '0;
      soc_rst_n_o <= 1'b0;
      pads_live_o <= 1'b0;
    end else begin
      btn_sync_q  <= {btn_sync_q[0], sys_rst_i};
      state_q     <= state_d;
      hold_cnt_q  <= hold_cnt_d;
      // registered from next state, so outputs follow the fsm edge
      soc_rst_n_o <= (state_d == rst_run);
      pads_live_o <= (state_d == rst_run);
    end
  end

  // soc reset drops on the edge after a synced press
  a_press_holds_rst : assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    btn_sync |=> !soc_rst_n_o
  );

  // only the three legal encodings
  a_state_legal : assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    state_q inside {rst_assert, rst_hold, rst_run}
  );

endmodule

/* run.sh */
#!/bin/sh
# build and run the board glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module tb_board_glue -f files.f; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_board_glue 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TEST OK"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* sd_spi_pads.sv */
// registered mapping of the spi host onto the sd slot in spi mode
`timescale 1ns/1ps

module sd_spi_pads
  import board_io_pkg::*;
(
  input  logic      soc_clk,
  input  logic      rst_n,
  input  logic      pads_live_i,
  input  spi_host_t spi_host_i,
  input  logic      sd_dat0_i,
  output sd_pads_t  sd_pads_o,
  output logic      spi_miso_o
);

  sd_pads_t sd_next;

  //////////////////////////////
  // pin mapping
  //////////////////////////////

  always_comb begin
    // dat1/dat2 unused in spi mode, card reset kept low
    sd_next = sd_pads_idle;
    if (pads_live_i) begin
      // sck onto sd clk, idles high when disabled
      sd_next.sclk = spi_host_i.sck_en ? spi_host_i.sck : 1'b1;
      // chip select 0 onto dat3
      sd_next.dat3 = spi_host_i.csb_en[0] ? spi_host_i.csb[0] : 1'b1;
      // mosi onto cmd
      sd_next.cmd  = spi_host_i.sd_en[0] ? spi_host_i.sd_out[0] : 1'b1;
    end
  end

  //////////////////////////////
  // output flops
  //////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sd_pads_o  <= sd_pads_idle;
      spi_miso_o <= 1'b0;
    end else begin
      sd_pads_o  <= sd_next;
      // miso comes back on dat0
      spi_miso_o <= sd_dat0_i;
    end
  end

  // card must stay powered whatever the host does
  a_card_powered : assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    sd_pads_o.reset == 1'b0
  );

endmodule

/* tb_board_glue.sv */
// testbench for board_glue_top with clock, stimulus, reference functions and compare tasks
`timescale 1ns/1ps

module tb_board_glue
  import board_cfg_pkg::*;
  import board_io_pkg::*;
();

  logic       soc_clk = 1'b0;
  logic       rst_n;
  logic       sys_rst_i;
  spi_host_t  spi_host_i;
  logic       sd_dat0_i;
  i2c_host_t  i2c_host_i;
  logic       i2c_scl_i;
  logic       i2c_sda_i;
  logic [3:0] fan_sw_i;
  logic       soc_rst_n_o;
  logic       rtc_clk_o;
  sd_pads_t   sd_pads_o;
  logic       spi_miso_o;
  i2c_pads_t  i2c_pads_o;
  logic       i2c_scl_sync_o;
  logic       i2c_sda_sync_o;
  logic       fan_pwm_o;

  // checker enables and expected pad release, written on posedge only
  logic       chk_pads;
  logic       chk_rst_low;
  logic       exp_live;
  // inputs seen one and two cycles back
  spi_host_t  prev_spi;
  logic       prev_dat0;
  i2c_host_t  prev_i2c;
  logic [1:0] line_d1;
  logic [1:0] line_d2;
  int         cycles;
  int         high_cnt;
  logic [3:0] fan_set [3] = '{4'd0, 4'd5, 4'd15};

  board_glue_top dut (.*);

  // 50 MHz
  always #10 soc_clk = ~soc_clk;

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic sd_pads_t ref_sd_pads(input logic live, input spi_host_t h);
    sd_pads_t r;
    // unused data lines high, card reset low
    r.dat2_1 = 2'b11;
    r.reset  = 1'b0;
    r.sclk   = (live && h.sck_en) ? h.sck : 1'b1;
    r.dat3   = (live && h.csb_en[0]) ? h.csb[0] : 1'b1;
    r.cmd    = (live && h.sd_en[0]) ? h.sd_out[0] : 1'b1;
    return r;
  endfunction

  function automatic i2c_pads_t ref_i2c_pads(input logic live, input i2c_host_t h);
    i2c_pads_t r;
    // pull low only for an enabled zero
    r.scl_oe = live && h.scl_en && !h.scl_out;
    r.sda_oe = live && h.sda_en && !h.sda_out;
    return r;
  endfunction

  // high cycles in one 16-step pwm window
  function automatic int ref_pwm_high(input logic [3:0] setting);
    int n;
    n = 0;
    for (int s = 0; s < 16; s++) begin
      if (s < setting) n++;
    end
    return n;
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_sd(input sd_pads_t act, input sd_pads_t exp, input string what);
    if (act !== exp) begin
      abort_run($sformatf("Fail at %0t: %s got %b expected %b", $time, what, act, exp));
    end
  endtask

  task automatic check_i2c(input i2c_pads_t act, input i2c_pads_t exp, input string what);
    if (act !== exp) begin
      abort_run($sformatf("Fail at %0t: %s got %b expected %b", $time, what, act, exp));
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      abort_run($sformatf("Fail at %0t: %s got %b expected %b", $time, what, act, exp));
    end
  endtask

  task automatic check_count(input int act, input int exp, input string what);
    if (act != exp) begin
      abort_run($sformatf("Fail at %0t: %s got %0d expected %0d", $time, what, act, exp));
    end
  endtask

  // comparing process, outputs settled mid-cycle
  always @(negedge soc_clk) begin
    if (chk_pads) begin
      check_sd(sd_pads_o, ref_sd_pads(exp_live, prev_spi), "sd pads");
      check_bit(spi_miso_o, prev_dat0, "spi miso");
      check_i2c(i2c_pads_o, ref_i2c_pads(exp_live, prev_i2c), "i2c oe");
      check_bit(i2c_scl_sync_o, line_d2[1], "scl sync");
      check_bit(i2c_sda_sync_o, line_d2[0], "sda sync");
    end
    if (chk_rst_low) check_bit(soc_rst_n_o, 1'b0, "soc reset while pressed");
    line_d2   = line_d1;
    line_d1   = {i2c_scl_i, i2c_sda_i};
    prev_spi  = spi_host_i;
    prev_dat0 = sd_dat0_i;
    prev_i2c  = i2c_host_i;
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // one random word per cycle covers every pad input
  task automatic drive_random();
    logic [31:0] rnd;
    rnd = $urandom;
    spi_host_i <= rnd[13:0];
    i2c_host_i <= rnd[17:14];
    sd_dat0_i  <= rnd[18];
    i2c_scl_i  <= rnd[19];
    i2c_sda_i  <= rnd[20];
  endtask

  // cycles counted in whole posedges until the level shows
  task automatic wait_rtc(input logic level, input int limit, output int n);
    n = 0;
    do begin
      @(posedge soc_clk);
      @(negedge soc_clk);
      n++;
      if (rtc_clk_o !== level && n >= limit) abort_run("rtc clock stopped toggling");
    end while (rtc_clk_o !== level);
  endtask

  task automatic wait_soc_rst(input logic level, input int limit, output int n);
    n = 0;
    do begin
      @(posedge soc_clk);
      @(negedge soc_clk);
      n++;
      if (soc_rst_n_o !== level && n >= limit) begin
        abort_run($sformatf("soc reset did not go to %b within %0d cycles", level, limit));
      end
    end while (soc_rst_n_o !== level);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h5d83));
    rst_n       = 1'b0;
    sys_rst_i   = 1'b1;
    spi_host_i  = '0;
    sd_dat0_i   = 1'b0;
    i2c_host_i  = '0;
    i2c_scl_i   = 1'b1;
    i2c_sda_i   = 1'b1;
    fan_sw_i    = 4'd0;
    chk_pads    = 1'b0;
    chk_rst_low = 1'b0;
    exp_live    = 1'b0;
    repeat (2) @(posedge soc_clk);
    rst_n <= 1'b1;

    // rtc, first rise then 8 full periods
    wait_rtc(1'b1, rtc_half_period + 5, cycles);
    check_count(cycles, rtc_half_period, "rtc first rise");
    for (int i = 0; i < 16; i++) begin
      wait_rtc(i[0], rtc_half_period + 5, cycles);
      check_count(cycles, rtc_half_period, "rtc half period");
    end

    // button held, pads idle and soc in reset
    @(posedge soc_clk);
    chk_pads    = 1'b1;
    chk_rst_low = 1'b1;
    repeat (100) begin
      @(posedge soc_clk);
      drive_random();
    end

    // release, latency depends on tick phase
    @(posedge soc_clk);
    chk_pads    = 1'b0;
    chk_rst_low = 1'b0;
    sys_rst_i <= 1'b0;
    wait_soc_rst(1'b1, 2 + rst_hold_ticks * rtc_half_period + 10, cycles);
    if (cycles < 2 + (rst_hold_ticks - 1) * rtc_half_period ||
        cycles > 2 + rst_hold_ticks * rtc_half_period + 1) begin
      abort_run($sformatf("Fail at %0t: soc reset released after %0d cycles", $time, cycles));
    end

    // live pads, random sd and i2c traffic
    @(posedge soc_clk);
    exp_live = 1'b1;
    chk_pads = 1'b1;
    repeat (200) begin
      @(posedge soc_clk);
      drive_random();
    end

    // second press
    @(posedge soc_clk);
    chk_pads = 1'b0;
    sys_rst_i <= 1'b1;
    wait_soc_rst(1'b0, 3, cycles);

    // fan duty windows
    foreach (fan_set[i]) begin
      @(posedge soc_clk);
      fan_sw_i <= fan_set[i];
      repeat (4) @(posedge soc_clk);
      high_cnt = 0;
      repeat (16) begin
        @(negedge soc_clk);
        if (fan_pwm_o) high_cnt++;
      end
      check_count(high_cnt, ref_pwm_high(fan_set[i]), "fan pwm high cycles");
    end

    $display("TEST OK");
    $finish;
  end

endmodule
